//--- project.f
+incdir+sim
rtl/lcdPkg.sv
rtl/lcdInitRom.sv
rtl/lcdWriteCapture.sv
rtl/lcdSequencer.sv
rtl/lcdNibbleWriter.sv
rtl/lcdControl.sv
sim/lcdControlTb.sv

//--- rtl/lcdControl.sv
`timescale 1ns/1ps

module lcdControl
#(
        parameter lcdPkg::timerCount_t PowerOnCycles     = 750000,     // 15 ms
        parameter lcdPkg::timerCount_t LongWaitCycles    = 205000,     // 4.1 ms
        parameter lcdPkg::timerCount_t WakeWaitCycles    = 5000,       // 100 us
        parameter lcdPkg::timerCount_t CmdWaitCycles     = 2000,       // 40 us
        parameter lcdPkg::timerCount_t NibbleWaitCycles  = 50,         // 1 us
        parameter lcdPkg::timerCount_t ClearWaitCycles   = 82000,      // 1.64 ms
        parameter lcdPkg::timerCount_t EnablePulseCycles = 12          // 240 ns
)
(
        input  logic               Clock,
        input  logic               reset,
        input  logic               Write,
        input  lcdPkg::lcdByte_t   Data,
        output logic               Ready,
        output logic               LcdEnable,
        output logic               LcdRegisterSelect,
        output logic               LcdReadWrite,
        output logic               LcdFlashDisable,
        output lcdPkg::lcdNibble_t LcdData
);
        import lcdPkg::*;

        // capture to sequencer
        logic       byteValid;
        logic       lowHalf;
        logic       take;
        lcdNibble_t nibble;

        // sequencer to writer
        logic       start;
        logic       done;
        logic       startRegSelect;
        lcdNibble_t startNibble;
        waitSel_t   startWait;

        // write only, flash kept off the shared bus
        assign LcdReadWrite    = 1'b0;
        assign LcdFlashDisable = 1'b1;

        lcdWriteCapture writeCapture
        (
                .Clock     (Clock),
                .reset     (reset),
                .Write     (Write),
                .Data      (Data),
                .Ready     (Ready),
                .take      (take),
                .byteValid (byteValid),
                .nibble    (nibble),
                .lowHalf   (lowHalf)
        );

        lcdSequencer sequencer
        (
                .Clock          (Clock),
                .reset          (reset),
                .done           (done),
                .byteValid      (byteValid),
                .nibble         (nibble),
                .lowHalf        (lowHalf),
                .Ready          (Ready),
                .take           (take),
                .start          (start),
                .startNibble    (startNibble),
                .startRegSelect (startRegSelect),
                .startWait      (startWait)
        );

        lcdNibbleWriter #(
                .PowerOnCycles     (PowerOnCycles),
                .LongWaitCycles    (LongWaitCycles),
                .WakeWaitCycles    (WakeWaitCycles),
                .CmdWaitCycles     (CmdWaitCycles),
                .NibbleWaitCycles  (NibbleWaitCycles),
                .ClearWaitCycles   (ClearWaitCycles),
                .EnablePulseCycles (EnablePulseCycles)
        ) nibbleWriter (
                .Clock             (Clock),
                .reset             (reset),
                .start             (start),
                .startNibble       (startNibble),
                .startRegSelect    (startRegSelect),
                .startWait         (startWait),
                .done              (done),
                .LcdEnable         (LcdEnable),
                .LcdRegisterSelect (LcdRegisterSelect),
                .LcdData           (LcdData)
        );

endmodule

//--- rtl/lcdInitRom.sv
`timescale 1ns/1ps

module lcdInitRom
(
        input  lcdPkg::initIndex_t step,
        output lcdPkg::lcdNibble_t romNibble,
        output lcdPkg::waitSel_t   romWait
);
        import lcdPkg::*;

        // nibble sent at each step
        localparam lcdNibble_t NibbleTable [InitSteps] = '{
                4'h3, 4'h3, 4'h3,       // wake-up, still in 8-bit mode
                4'h2,                   // switch to 4-bit bus
                4'h2, 4'h8,             // 0x28 function set, 2 lines 5x8
                4'h0, 4'h6,             // 0x06 entry mode, increment
                4'h0, 4'hC,             // 0x0C display on, no cursor
                4'h0, 4'h1,             // 0x01 clear display
                4'h8, 4'h0              // 0x80 ddram address 0
        };

        // settle wait following each step
        localparam waitSel_t WaitTable [InitSteps] = '{
                WaitLong, WaitWake, WaitCmd,
                WaitCmd,
                WaitNibble, WaitCmd,
                WaitNibble, WaitCmd,
                WaitNibble, WaitCmd,
                WaitNibble, WaitClear,  // clear needs the long one
                WaitNibble, WaitCmd
        };

        // steps 14 and 15 never addressed, kept harmless
        assign romNibble = (step < InitSteps) ? NibbleTable[step] : '0;
        assign romWait   = (step < InitSteps) ? WaitTable[step] : WaitCmd;

endmodule

//--- rtl/lcdNibbleWriter.sv
`timescale 1ns/1ps

module lcdNibbleWriter
#(
        parameter lcdPkg::timerCount_t PowerOnCycles     = 750000,
        parameter lcdPkg::timerCount_t LongWaitCycles    = 205000,
        parameter lcdPkg::timerCount_t WakeWaitCycles    = 5000,
        parameter lcdPkg::timerCount_t CmdWaitCycles     = 2000,
        parameter lcdPkg::timerCount_t NibbleWaitCycles  = 50,
        parameter lcdPkg::timerCount_t ClearWaitCycles   = 82000,
        parameter lcdPkg::timerCount_t EnablePulseCycles = 12
)
(
        input  logic               Clock,
        input  logic               reset,
        input  logic               start,
        input  lcdPkg::lcdNibble_t startNibble,
        input  logic               startRegSelect,
        input  lcdPkg::waitSel_t   startWait,
        output logic               done,
        output logic               LcdEnable,
        output logic               LcdRegisterSelect,
        output lcdPkg::lcdNibble_t LcdData
);
        import lcdPkg::*;

        typedef enum logic [1:0] {
                WriterPowerOn,
                WriterIdle,
                WriterPulse,
                WriterSettle
        } writerState_t;

        writerState_t state;
        timerCount_t  timer;
        timerCount_t  waitCount;        // settle length of the current nibble
        timerCount_t  selCount;
        logic         pulseEnd;
        logic         settleEnd;

        // wait class to cycles
        always_comb
        begin
                case (startWait)
                WaitPowerOn: selCount = PowerOnCycles;
                WaitLong:    selCount = LongWaitCycles;
                WaitWake:    selCount = WakeWaitCycles;
                WaitNibble:  selCount = NibbleWaitCycles;
                WaitClear:   selCount = ClearWaitCycles;
                default:     selCount = CmdWaitCycles;
                endcase
        end

        assign pulseEnd  = (timer == EnablePulseCycles - timerCount_t'(1));
        assign settleEnd = (timer == waitCount - timerCount_t'(1));

        // last cycle of a wait, power-on included
        assign done = settleEnd && ((state == WriterSettle) || (state == WriterPowerOn));

        // --------------------------------------------------
        // timer and pins
        // --------------------------------------------------
        always_ff @(posedge Clock)
        begin
                if (reset)
                begin
                        state             <= WriterPowerOn;
                        timer             <= '0;
                        waitCount         <= PowerOnCycles;     // counts on its own after reset
                        LcdEnable         <= 1'b0;
                        LcdRegisterSelect <= 1'b0;
                        LcdData           <= '0;
                end
                else
                begin
                        case (state)
                        WriterPowerOn, WriterSettle:
                                if (settleEnd)
                                begin
                                        state <= WriterIdle;
                                        timer <= '0;
                                end
                                else
                                begin
                                        timer <= timer + 1'b1;
                                end
                        WriterIdle:
                                if (start)
                                begin
                                        state             <= WriterPulse;
                                        timer             <= '0;
                                        waitCount         <= selCount;
                                        LcdEnable         <= 1'b1;
                                        LcdData           <= startNibble;       // held until next start
                                        LcdRegisterSelect <= startRegSelect;
                                end
                        WriterPulse:
                                if (pulseEnd)
                                begin
                                        state     <= WriterSettle;
                                        timer     <= '0;
                                        LcdEnable <= 1'b0;      // display latches on this fall
                                end
                                else
                                begin
                                        timer <= timer + 1'b1;
                                end
                        default:
                                state <= WriterIdle;
                        endcase
                end
        end

        // enable width bounded by the pulse parameter
        assert property (@(posedge Clock) disable iff (reset)
                LcdEnable [*EnablePulseCycles] |=> !LcdEnable);

endmodule

//--- rtl/lcdPkg.sv
package lcdPkg;

        // --------------------------------------------------
        // bus and data widths
        // --------------------------------------------------
        typedef logic [3:0] lcdNibble_t;        // one nibble on LcdData
        typedef logic [7:0] lcdByte_t;          // command or character byte

        // 20 bits reach 750000 cycles, 15 ms at 50 MHz
        typedef logic [19:0] timerCount_t;

        // --------------------------------------------------
        // settle waits after an enable pulse
        // --------------------------------------------------
        typedef enum logic [2:0] {
                WaitPowerOn,    // 15 ms before anything
                WaitLong,       // 4.1 ms after first wake-up
                WaitWake,       // 100 us
                WaitCmd,        // 40 us for most commands
                WaitNibble,     // 1 us between the halves of a byte
                WaitClear       // 1.64 ms for clear display
        } waitSel_t;

        // start-up table
        typedef logic [3:0] initIndex_t;
        localparam int InitSteps = 14;  // 4 wake-up nibbles plus 5 bytes

endpackage

//--- rtl/lcdSequencer.sv
`timescale 1ns/1ps

module lcdSequencer
(
        input  logic               Clock,
        input  logic               reset,
        input  logic               done,           // writer finished its wait
        input  logic               byteValid,
        input  lcdPkg::lcdNibble_t nibble,
        input  logic               lowHalf,
        output logic               Ready,
        output logic               take,
        output logic               start,
        output lcdPkg::lcdNibble_t startNibble,
        output logic               startRegSelect,
        output lcdPkg::waitSel_t   startWait
);
        import lcdPkg::*;

        typedef enum logic [2:0] {
                SeqPowerOn,
                SeqInitIssue,
                SeqInitWait,
                SeqIdle,
                SeqDataIssue,
                SeqDataWait
        } seqState_t;

        seqState_t  state;
        initIndex_t step;       // current start-up table entry
        lcdNibble_t romNibble;
        waitSel_t   romWait;

        lcdInitRom initRom
        (
                .step      (step),
                .romNibble (romNibble),
                .romWait   (romWait)
        );

        // --------------------------------------------------
        // state register
        // --------------------------------------------------
        always_ff @(posedge Clock)
        begin
                if (reset)
                begin
                        state <= SeqPowerOn;
                        step  <= '0;
                end
                else
                begin
                        case (state)
                        SeqPowerOn:
                                if (done)       // first done ends the power-on delay
                                begin
                                        state <= SeqInitIssue;
                                        step  <= '0;
                                end
                        SeqInitIssue:
                                state <= SeqInitWait;
                        SeqInitWait:
                                if (done)
                                begin
                                        if (step == initIndex_t'(InitSteps - 1))
                                        begin
                                                state <= SeqIdle;       // table done
                                        end
                                        else
                                        begin
                                                step  <= step + 1'b1;
                                                state <= SeqInitIssue;
                                        end
                                end
                        SeqIdle:
                                if (byteValid)
                                begin
                                        state <= SeqDataIssue;
                                end
                        SeqDataIssue:
                                state <= SeqDataWait;
                        SeqDataWait:
                                if (done)
                                begin
                                        // low half still pending after the first nibble
                                        state <= byteValid ? SeqDataIssue : SeqIdle;
                                end
                        default:
                                state <= SeqPowerOn;
                        endcase
                end
        end

        // --------------------------------------------------
        // outputs decoded from state
        // --------------------------------------------------
        assign Ready          = (state == SeqIdle);
        assign take           = (state == SeqDataIssue);
        assign start          = (state == SeqInitIssue) || (state == SeqDataIssue);
        assign startRegSelect = (state == SeqDataIssue);        // data vs command
        assign startNibble    = (state == SeqDataIssue) ? nibble : romNibble;

        always_comb
        begin
                if (state == SeqDataIssue)
                begin
                        startWait = lowHalf ? WaitCmd : WaitNibble;    // short gap mid byte
                end
                else
                begin
                        startWait = romWait;
                end
        end

        // one transfer in flight at a time
        assert property (@(posedge Clock) disable iff (reset)
                start |=> (!start until done));

endmodule

//--- rtl/lcdWriteCapture.sv
`timescale 1ns/1ps

module lcdWriteCapture
(
        input  logic               Clock,
        input  logic               reset,
        input  logic               Write,
        input  lcdPkg::lcdByte_t   Data,
        input  logic               Ready,
        input  logic               take,      // sequencer used the current nibble
        output logic               byteValid,
        output lcdPkg::lcdNibble_t nibble,
        output logic               lowHalf
);
        import lcdPkg::*;

        lcdByte_t byteHeld;     // payload, no reset
        logic     accept;

        // only one byte at a time, and only while idle
        assign accept = Write && Ready && !byteValid;

        always_ff @(posedge Clock)
        begin
                if (accept)
                begin
                        byteHeld <= Data;
                end
        end

        // --------------------------------------------------
        // half tracking
        // --------------------------------------------------
        always_ff @(posedge Clock)
        begin
                if (reset)
                begin
                        byteValid <= 1'b0;
                        lowHalf   <= 1'b0;
                end
                else if (accept)
                begin
                        byteValid <= 1'b1;
                        lowHalf   <= 1'b0;      // high nibble goes first
                end
                else if (take)
                begin
                        if (lowHalf)
                        begin
                                byteValid <= 1'b0;      // both halves gone
                                lowHalf   <= 1'b0;
                        end
                        else
                        begin
                                lowHalf <= 1'b1;
                        end
                end
        end

        assign nibble = lowHalf ? byteHeld[3:0] : byteHeld[7:4];

        // sequencer must only take what is there
        assert property (@(posedge Clock) disable iff (reset) take |-> byteValid);

endmodule

//--- sim/lcdControlModel.svh
// expected values for one enable pulse
typedef struct packed {
        lcdNibble_t  nibble;
        logic        regSelect;
        logic [31:0] minLow;    // low cycles needed before the pulse
} transfer_t;

// start-up bytes after the four wake-up nibbles
localparam lcdByte_t InitCommands [5] = '{8'h28, 8'h06, 8'h0C, 8'h01, 8'h80};

// --------------------------------------------------
// wait classes in cycles
// --------------------------------------------------
function automatic logic [31:0] waitCycles(input waitSel_t waitClass);
        case (waitClass)
        WaitPowerOn: return PowerOnCycles;
        WaitLong:    return LongWaitCycles;
        WaitWake:    return WakeWaitCycles;
        WaitNibble:  return NibbleWaitCycles;
        WaitClear:   return ClearWaitCycles;
        default:     return CmdWaitCycles;
        endcase
endfunction

// settle wait that follows transfer p
function automatic waitSel_t waitAfter(input int p);
        if (p == 0)
                return WaitLong;
        if (p == 1)
                return WaitWake;
        if (p < 4)
                return WaitCmd;         // third wake-up and the 4-bit switch
        if (p < InitSteps)
        begin
                if ((p - 4) % 2 == 0)
                        return WaitNibble;
                return (InitCommands[(p - 4) / 2] == 8'h01) ? WaitClear : WaitCmd;
        end
        return ((p - InitSteps) % 2 == 0) ? WaitNibble : WaitCmd;      // data byte halves
endfunction

// --------------------------------------------------
// reference for transfer k since reset
// --------------------------------------------------
function automatic transfer_t expectedTransfer(input int k, input lcdByte_t dataByte);
        transfer_t t;
        int        j;
        if (k < InitSteps)
        begin
                t.regSelect = 1'b0;
                if (k < 4)
                begin
                        t.nibble = (k < 3) ? 4'h3 : 4'h2;
                end
                else
                begin
                        j = k - 4;
                        t.nibble = (j % 2 == 0) ? InitCommands[j / 2][7:4]
                                                : InitCommands[j / 2][3:0];
                end
        end
        else
        begin
                j = k - InitSteps;
                t.regSelect = 1'b1;     // character data
                t.nibble    = (j % 2 == 0) ? dataByte[7:4] : dataByte[3:0];
        end
        t.minLow = (k == 0) ? PowerOnCycles : waitCycles(waitAfter(k - 1));
        return t;
endfunction

// stop the run as failed
task automatic abortRun();
        $display("CHECKS FAILED");
        $fatal(1, "simulation stopped on error");
endtask

task automatic checkValue(input string name, input logic [31:0] actual,
                          input logic [31:0] expected);
        if (actual !== expected)
        begin
                $display("** Error at %0t ns: %s is %0d, expected %0d",
                         $time, name, actual, expected);
                abortRun();
        end
endtask

//--- sim/lcdControlTb.sv
`timescale 1ns/1ps

module lcdControlTb;
        import lcdPkg::*;

        // --------------------------------------------------
        // shortened display timing
        // --------------------------------------------------
        localparam int EnablePulseCycles = 3;
        localparam int PowerOnCycles     = 40;
        localparam int LongWaitCycles    = 20;
        localparam int WakeWaitCycles    = 12;
        localparam int CmdWaitCycles     = 8;
        localparam int NibbleWaitCycles  = 4;
        localparam int ClearWaitCycles   = 16;
        localparam int LongestWait       = LongWaitCycles;     // long beats clear here
        localparam int RandomBytes       = 20;
        localparam int TotalBytes        = RandomBytes + 3;    // interrupted byte, two after reset
        localparam int WatchdogCycles    = (2 * InitSteps + 2 * TotalBytes)
                                           * (EnablePulseCycles + LongestWait) * 2
                                           + 2 * PowerOnCycles;     // two start-ups
        localparam int ClockPeriod       = 40;
        localparam int Seed              = 50452;

        logic       Clock;
        logic       reset;
        logic       Write;
        lcdByte_t   Data;
        logic       Ready;
        logic       LcdEnable;
        logic       LcdRegisterSelect;
        logic       LcdReadWrite;
        logic       LcdFlashDisable;
        lcdNibble_t LcdData;

        lcdByte_t expectedBytes [$];    // accepted bytes since reset
        int       pulseCount = 0;       // finished enable pulses since reset
        int       highCycles = 0;
        int       lowCycles  = 0;

        `include "lcdControlModel.svh"

        lcdControl #(
                .PowerOnCycles     (PowerOnCycles),
                .LongWaitCycles    (LongWaitCycles),
                .WakeWaitCycles    (WakeWaitCycles),
                .CmdWaitCycles     (CmdWaitCycles),
                .NibbleWaitCycles  (NibbleWaitCycles),
                .ClearWaitCycles   (ClearWaitCycles),
                .EnablePulseCycles (EnablePulseCycles)
        ) uut (
                .Clock             (Clock),
                .reset             (reset),
                .Write             (Write),
                .Data              (Data),
                .Ready             (Ready),
                .LcdEnable         (LcdEnable),
                .LcdRegisterSelect (LcdRegisterSelect),
                .LcdReadWrite      (LcdReadWrite),
                .LcdFlashDisable   (LcdFlashDisable),
                .LcdData           (LcdData)
        );

        initial
        begin
                Clock = 1'b0;
                forever #(ClockPeriod / 2) Clock = ~Clock;
        end

        initial
        begin
                #(longint'(WatchdogCycles) * ClockPeriod);
                $display("timeout: the run did not end within %0d cycles", WatchdogCycles);
                abortRun();
        end

        // --------------------------------------------------
        // pulse monitor, sampled on the falling clock edge
        // --------------------------------------------------
        always @(negedge Clock)
        begin : monitorPulses
                transfer_t refTransfer;
                lcdByte_t  dataByte;
                int        k;
                if (reset)
                begin
                        pulseCount = 0;
                        highCycles = 0;
                        lowCycles  = 0;
                        expectedBytes.delete();         // display starts over
                end
                else
                begin
                        checkValue("LcdReadWrite", LcdReadWrite, 1'b0);
                        checkValue("LcdFlashDisable", LcdFlashDisable, 1'b1);
                        k = pulseCount;
                        dataByte = '0;
                        if (k >= InitSteps)
                        begin
                                if ((k - InitSteps) / 2 < expectedBytes.size())
                                begin
                                        dataByte = expectedBytes[(k - InitSteps) / 2];
                                end
                                else if (LcdEnable)     // pulse without a written byte
                                begin
                                        $display("error at %0t ns: enable pulse %0d has no byte",
                                                 $time, k);
                                        abortRun();
                                end
                        end
                        refTransfer = expectedTransfer(k, dataByte);
                        if (LcdEnable)
                        begin
                                if (highCycles == 0)    // rising edge, check the gap
                                begin
                                        checkValue("LcdEnable low time",
                                                   (lowCycles < refTransfer.minLow) ? lowCycles
                                                                                    : refTransfer.minLow,
                                                   refTransfer.minLow);
                                end
                                highCycles++;
                        end
                        else if (highCycles != 0)      // first low sample after the fall
                        begin
                                checkValue("LcdEnable width", highCycles, EnablePulseCycles);
                                checkValue("LcdData", LcdData, refTransfer.nibble);
                                checkValue("LcdRegisterSelect", LcdRegisterSelect,
                                           refTransfer.regSelect);
                                pulseCount++;
                                highCycles = 0;
                                lowCycles  = 1;
                        end
                        else
                        begin
                                lowCycles++;
                        end
                        // Ready only after a whole byte or start-up and its wait
                        if (Ready)
                        begin
                                checkValue("Ready", 1'b1,
                                           (pulseCount >= InitSteps)
                                           && ((pulseCount - InitSteps) % 2 == 0)
                                           && !LcdEnable
                                           && (lowCycles >= expectedTransfer(pulseCount, 8'h00).minLow));
                        end
                end
        end

        // --------------------------------------------------
        // stimulus helpers
        // --------------------------------------------------
        task automatic waitReady();
                while (!Ready)
                        @(negedge Clock);
        endtask

        task automatic checkResetOutputs();
                checkValue("LcdEnable", LcdEnable, 1'b0);
                checkValue("Ready", Ready, 1'b0);
                checkValue("LcdRegisterSelect", LcdRegisterSelect, 1'b0);
                checkValue("LcdData", LcdData, 4'h0);
        endtask

        // write that must be ignored
        task automatic strayWrite();
                checkValue("Ready", Ready, 1'b0);
                Write <= 1'b1;
                Data  <= lcdByte_t'($urandom);
                @(negedge Clock);
                Write <= 1'b0;
        endtask

        task automatic writeByte(input lcdByte_t value, input logic addStray);
                waitReady();
                Write <= 1'b1;
                Data  <= value;
                @(negedge Clock);
                Write <= 1'b0;
                expectedBytes.push_back(value);
                @(negedge Clock);
                checkValue("Ready", Ready, 1'b0);      // low within two cycles
                if (addStray)
                        strayWrite();
                waitReady();
                checkValue("pulse count", pulseCount, InitSteps + 2 * expectedBytes.size());
        endtask

        initial
        begin : stimulus
                int unsigned seedValue;
                lcdByte_t    cutByte;
                seedValue = $urandom(Seed);
                reset = 1'b1;
                Write = 1'b0;
                Data  = '0;
                repeat (2) @(negedge Clock);
                reset <= 1'b0;
                checkResetOutputs();
                repeat (3)
                begin
                        repeat (5) @(negedge Clock);
                        strayWrite();           // during power-on wait
                end
                waitReady();
                checkValue("start-up pulse count", pulseCount, InitSteps);
                for (int i = 0; i < RandomBytes; i++)
                        writeByte(lcdByte_t'($urandom), (i % 3 == 0));

                // reset during the high nibble of a byte
                waitReady();
                cutByte = lcdByte_t'($urandom);
                Write <= 1'b1;
                Data  <= cutByte;
                @(negedge Clock);
                Write <= 1'b0;
                expectedBytes.push_back(cutByte);
                while (!LcdEnable)
                        @(negedge Clock);
                @(negedge Clock);
                reset <= 1'b1;
                repeat (2) @(negedge Clock);
                reset <= 1'b0;
                checkResetOutputs();
                waitReady();
                checkValue("start-up pulse count", pulseCount, InitSteps);
                writeByte(lcdByte_t'($urandom), 1'b1);
                writeByte(lcdByte_t'($urandom), 1'b0);
                repeat (4) @(negedge Clock);
                $display("ALL CHECKS PASSED");
                $finish;
        end

endmodule
